// File: dmaCore.f
+incdir+.
dmaPkg.sv
dmaBusDecode.sv
dmaChannelRegs.sv
dmaTransferEngine.sv
dmaCore.sv
tbDmaChecker.sv
tbDmaCore.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbDmaCore -f dmaCore.f -o tbDmaCore
./obj_dir/tbDmaCore > sim.log 2>&1 || true
cat sim.log

if grep -q '>>> FAIL' sim.log; then
  exit 1
fi
grep -q '>>> PASS' sim.log

// File: tbDmaCore.sv
// Testbench top with clock, reset, xorshift stimulus, watchdog and the DUT
`timescale 1ns/1ps
`include "dma_params.svh"

module tbDmaCore;

  // Rough length of each test in cycles, summed for the watchdog
  localparam int testCycles   = 300 + 200 + 200 + 150 + 150 + 150;
  localparam int marginFactor = 4;

  logic                       clk;
  logic                       arstN;
  logic                       cs;
  logic                       rd;
  logic                       wr;
  logic [`DMA_REG_ADDR_W-1:0] regAddr;
  logic [`DMA_DATA_W-1:0]     wrData;
  logic [`DMA_DATA_W-1:0]     rdData;
  logic [`DMA_CHANNELS-1:0]   dreq;
  logic [`DMA_CHANNELS-1:0]   dack;
  logic [`DMA_ADDR_W-1:0]     memAddr;
  logic [31:0]                rngState;
  int                         testsRun;
  int                         testsFailed;
  int                         errorCount;

  dmaCore dut_i (
    .clk(clk), .arstN(arstN), .cs(cs), .rd(rd), .wr(wr), .regAddr(regAddr),
    .wrData(wrData), .rdData(rdData), .dreq(dreq), .dack(dack), .memAddr(memAddr)
  );

  tbDmaChecker checker_i (
    .clk(clk), .arstN(arstN), .cs(cs), .rd(rd), .wr(wr), .regAddr(regAddr),
    .wrData(wrData), .dreq(dreq), .rdData(rdData), .dack(dack), .memAddr(memAddr),
    .testsRun(testsRun), .testsFailed(testsFailed), .errorCount(errorCount)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // One register access, strobes held for a single edge
  task automatic access(input logic isWrite, input logic [3:0] addr, input logic [7:0] data);
    @(posedge clk);
    cs      <= 1'b1;
    rd      <= !isWrite;
    wr      <= isWrite;
    regAddr <= addr;
    wrData  <= data;
    @(posedge clk);
    cs <= 1'b0;
    rd <= 1'b0;
    wr <= 1'b0;
  endtask

  task automatic write16(input logic [3:0] addr, input logic [15:0] value);
    access(1'b1, 4'd12, 8'h00);
    access(1'b1, addr, value[7:0]);
    access(1'b1, addr, value[15:8]);
  endtask

  task automatic read16(input logic [3:0] addr);
    access(1'b1, 4'd12, 8'h00);
    access(1'b0, addr, 8'h00);
    access(1'b0, addr, 8'h00);
  endtask

  task automatic setupChannel(input int ch, input logic [15:0] addr, input logic [15:0] count,
                              input logic [7:0] modeBits);
    access(1'b1, 4'd11, modeBits | 8'(ch));
    write16(4'(2 * ch), addr);
    write16(4'(2 * ch + 1), count);
  endtask

  task automatic setDreq(input logic [3:0] value);
    @(posedge clk);
    dreq <= value;
  endtask

  task automatic waitGrants(input int count);
    int seen;
    seen = 0;
    while (seen < count)
    begin
      @(negedge clk);
      if (dack != '0)
        seen++;
    end
  endtask

  initial
  begin
    logic [31:0] r;
    int          ch;
    int          cnt;
    clk      = 1'b0;
    arstN    = 1'b0;
    cs       = 1'b0;
    rd       = 1'b0;
    wr       = 1'b0;
    regAddr  = '0;
    wrData   = '0;
    dreq     = '0;
    rngState = 32'd16;
    repeat (3) @(posedge clk);
    arstN <= 1'b1;

    checker_i.startTest("regReadback");
    for (ch = 0; ch < 8; ch++)
      read16(4'(ch));
    access(1'b0, 4'd8, 8'h00);
    repeat (30)
    begin
      r = nextRand();
      case (r[1:0])
        2'd0:    write16(4'(r[4:2]), r[31:16]);
        2'd1:    read16(4'(r[4:2]));
        2'd2:    access(1'b1, 4'd12, 8'h00);
        default: access(r[5], 4'(r[4:2]), r[15:8]);
      endcase
    end
    repeat (3) @(posedge clk);
    checker_i.endTest();

    checker_i.startTest("maskPriority");
    for (ch = 0; ch < 4; ch++)
      setupChannel(ch, 16'(nextRand() >> 16), 16'd3, 8'h00);
    access(1'b1, 4'd15, 8'h0F);
    setDreq(4'hF);
    repeat (12) @(posedge clk);
    r = nextRand();
    access(1'b1, 4'd15, {4'h0, r[3:0]});
    repeat (12) @(posedge clk);
    access(1'b1, 4'd14, 8'h00);
    waitGrants(10);
    setDreq(4'h0);
    repeat (4) @(posedge clk);
    checker_i.endTest();

    checker_i.startTest("addrStep");
    for (cnt = 0; cnt < 2; cnt++)
    begin
      ch = int'(nextRand() >> 30);
      setupChannel(ch, 16'(nextRand() >> 16), 16'd5, cnt != 0 ? 8'h20 : 8'h00);
      access(1'b1, 4'd14, 8'h00);
      setDreq(4'b0001 << ch);
      waitGrants(3);
      setDreq(4'h0);
      repeat (3) @(posedge clk);
      read16(4'(2 * ch + 1));
      read16(4'(2 * ch));
    end
    repeat (3) @(posedge clk);
    checker_i.endTest();

    checker_i.startTest("termCount");
    ch  = int'(nextRand() >> 30);
    cnt = int'(nextRand() >> 29);
    setupChannel(ch, 16'(nextRand() >> 16), 16'(cnt), 8'h00);
    access(1'b1, 4'd14, 8'h00);
    access(1'b0, 4'd8, 8'h00);
    setDreq(4'b0001 << ch);
    waitGrants(cnt + 1);
    // Channel masks itself, held dreq must go unanswered
    repeat (12) @(posedge clk);
    access(1'b0, 4'd8, 8'h00);
    access(1'b0, 4'd8, 8'h00);
    setDreq(4'h0);
    repeat (3) @(posedge clk);
    checker_i.endTest();

    checker_i.startTest("autoInit");
    ch  = int'(nextRand() >> 30);
    cnt = int'(nextRand() >> 30);
    r   = nextRand();
    setupChannel(ch, r[31:16], 16'(cnt), 8'h10 | (r[7:0] & 8'h20));
    access(1'b1, 4'd14, 8'h00);
    setDreq(4'b0001 << ch);
    waitGrants(2 * cnt + 3);
    setDreq(4'h0);
    repeat (3) @(posedge clk);
    read16(4'(2 * ch));
    read16(4'(2 * ch + 1));
    repeat (3) @(posedge clk);
    checker_i.endTest();

    checker_i.startTest("masterClear");
    setupChannel(1, 16'(nextRand() >> 16), 16'(nextRand() >> 16), 8'h30);
    access(1'b1, 4'd15, 8'h0F);
    // Leave the byte pointer high before the clear
    access(1'b1, 4'd0, 8'h5A);
    access(1'b1, 4'd13, 8'h00);
    r = nextRand();
    access(1'b1, 4'd0, r[7:0]);
    access(1'b1, 4'd0, r[15:8]);
    for (ch = 0; ch < 8; ch++)
      read16(4'(ch));
    access(1'b0, 4'd8, 8'h00);
    setDreq(4'h1);
    waitGrants(1);
    setDreq(4'h0);
    repeat (4) @(posedge clk);
    checker_i.endTest();

    $display("Summary: %0d tests, %0d failed, %0d errors", testsRun, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    repeat (testCycles * marginFactor) @(posedge clk);
    $display("Watchdog: run did not finish within %0d cycles", testCycles * marginFactor);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tbDmaChecker.sv
// Testbench checker with a register-map and transfer model, port comparisons and test reports
`timescale 1ns/1ps
`include "dma_params.svh"

module tbDmaChecker (
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       cs,
  input  logic                       rd,
  input  logic                       wr,
  input  logic [`DMA_REG_ADDR_W-1:0] regAddr,
  input  logic [`DMA_DATA_W-1:0]     wrData,
  input  logic [`DMA_CHANNELS-1:0]   dreq,
  input  logic [`DMA_DATA_W-1:0]     rdData,
  input  logic [`DMA_CHANNELS-1:0]   dack,
  input  logic [`DMA_ADDR_W-1:0]     memAddr,
  output int                         testsRun,
  output int                         testsFailed,
  output int                         errorCount
);

  // Model of the register map
  logic [15:0] mBase [4];
  logic [15:0] mCur [4];
  logic [15:0] mBaseCnt [4];
  logic [15:0] mCurCnt [4];
  logic [3:0]  mAuto;
  logic [3:0]  mDec;
  logic [3:0]  mMask;
  logic [3:0]  mTc;
  logic        bytePtr;

  // Access taken at the previous edge, acted on at this one
  logic        pValid;
  logic        pRead;
  logic [3:0]  pAddr;
  logic [7:0]  pData;
  logic        pHi;

  // Transfer model, phase 0 idle, 1 grant, 2 update
  int          engPhase;
  int          svc;
  logic [7:0]  expRd;
  logic [3:0]  expDack;
  logic [15:0] expMem;

  string       testName;
  int          errorsAtStart;

  function automatic logic [15:0] withByte(input logic [15:0] old, input logic hi,
                                           input logic [7:0] b);
    return hi ? {b, old[7:0]} : {old[15:8], b};
  endfunction

  function automatic int firstSet(input logic [3:0] bits);
    int idx;
    idx = 0;
    for (int i = 3; i >= 0; i--)
    begin
      if (bits[i])
        idx = i;
    end
    return idx;
  endfunction

  task automatic clearModel();
    for (int i = 0; i < 4; i++)
    begin
      mBase[i]    = '0;
      mCur[i]     = '0;
      mBaseCnt[i] = '0;
      mCurCnt[i]  = '0;
    end
    mAuto = '0;
    mDec  = '0;
    mMask = '0;
    mTc   = '0;
  endtask

  task automatic compare(input string what, input logic [15:0] expVal,
                         input logic [15:0] actVal);
    if (expVal !== actVal)
    begin
      errorCount++;
      $display("ERROR test=%s %s expected %h actual %h", testName, what, expVal, actVal);
    end
  endtask

  task automatic startTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest();
    testsRun++;
    if (errorCount == errorsAtStart)
      $display("test %s: ok", testName);
    else
    begin
      testsFailed++;
      $display("test %s: %0d mismatches", testName, errorCount - errorsAtStart);
    end
  endtask

  initial
  begin
    testsRun    = 0;
    testsFailed = 0;
    errorCount  = 0;
    testName    = "none";
  end

  always @(posedge clk or negedge arstN)
  begin
    logic [3:0]  oldMask;
    logic [15:0] v;
    logic        tcHit;
    int          ch;
    if (!arstN)
    begin
      clearModel();
      bytePtr  = 1'b0;
      pValid   = 1'b0;
      engPhase = 0;
      svc      = 0;
      expRd    = '0;
      expDack  = '0;
      expMem   = '0;
    end
    else
    begin
      // Outputs of the cycle that just ended
      compare("rdData", {8'h00, expRd}, {8'h00, rdData});
      compare("dack", {12'h000, expDack}, {12'h000, dack});
      if (expDack != '0)
        compare("memAddr", expMem, memAddr);
      oldMask = mMask;
      ch      = int'(pAddr[2:1]);
      // Reads see the registers before this edge
      if (pValid && pRead)
      begin
        if (!pAddr[3])
        begin
          v     = pAddr[0] ? mCurCnt[ch] : mCur[ch];
          expRd = pHi ? v[15:8] : v[7:0];
        end
        else if (pAddr == 4'd8)
        begin
          expRd = {dreq, mTc};
          mTc   = '0;
        end
      end
      tcHit = 1'b0;
      if (engPhase == 2)
      begin
        tcHit        = (mCurCnt[svc] == '0);
        mCur[svc]    = mDec[svc] ? mCur[svc] - 16'd1 : mCur[svc] + 16'd1;
        mCurCnt[svc] = mCurCnt[svc] - 16'd1;
      end
      if (pValid && !pRead)
      begin
        if (!pAddr[3] && pAddr[0])
        begin
          mBaseCnt[ch] = withByte(mBaseCnt[ch], pHi, pData);
          mCurCnt[ch]  = withByte(mCurCnt[ch], pHi, pData);
        end
        else if (!pAddr[3])
        begin
          mBase[ch] = withByte(mBase[ch], pHi, pData);
          mCur[ch]  = withByte(mCur[ch], pHi, pData);
        end
        else if (pAddr == 4'd11)
        begin
          mAuto[pData[1:0]] = pData[4];
          mDec[pData[1:0]]  = pData[5];
        end
        else if (pAddr == 4'd13)
          clearModel();
        else if (pAddr == 4'd14)
          mMask = '0;
        else if (pAddr == 4'd15)
          mMask = pData[3:0];
      end
      // Terminal count, reload or self-mask
      if (tcHit)
      begin
        mTc[svc] = 1'b1;
        if (mAuto[svc])
        begin
          mCur[svc]    = mBase[svc];
          mCurCnt[svc] = mBaseCnt[svc];
        end
        else
          mMask[svc] = 1'b1;
      end
      expDack = '0;
      expMem  = '0;
      if (engPhase == 0 && (dreq & ~oldMask) != '0)
      begin
        svc      = firstSet(dreq & ~oldMask);
        engPhase = 1;
        expDack  = 4'b0001 << svc;
        expMem   = mCur[svc];
      end
      else if (engPhase == 1)
        engPhase = 2;
      else
        engPhase = 0;
      // Access at this edge, byte pointer moves now
      pValid = cs && (rd != wr);
      pRead  = rd;
      pAddr  = regAddr;
      pData  = wrData;
      pHi    = bytePtr;
      if (pValid && !regAddr[3])
        bytePtr = !bytePtr;
      else if (pValid && wr && (regAddr == 4'd12 || regAddr == 4'd13))
        bytePtr = 1'b0;
    end
  end

endmodule

// File: dmaCore.sv
// DMA controller top level connecting bus decoder, channel registers and transfer engine
`timescale 1ns/1ps
`include "dma_params.svh"

module dmaCore
  import dmaPkg::*;
(
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       cs,
  input  logic                       rd,
  input  logic                       wr,
  input  logic [`DMA_REG_ADDR_W-1:0] regAddr,
  input  logic [`DMA_DATA_W-1:0]     wrData,
  output logic [`DMA_DATA_W-1:0]     rdData,
  input  logic [`DMA_CHANNELS-1:0]   dreq,
  output logic [`DMA_CHANNELS-1:0]   dack,
  output logic [`DMA_ADDR_W-1:0]     memAddr
);

  // Decoder to register file
  dmaCmdE                   cmd;
  logic [`DMA_CH_W-1:0]     cmdChannel;
  logic                     hiByte;
  logic [`DMA_DATA_W-1:0]   cmdData;

  // Register file and engine
  logic [`DMA_CH_W-1:0]     svcChannel;
  logic [`DMA_ADDR_W-1:0]   chanAddr;
  logic [`DMA_ADDR_W-1:0]   chanCount;
  logic                     chanDecrement;
  logic [`DMA_CHANNELS-1:0] maskBits;
  logic                     update;
  logic [`DMA_ADDR_W-1:0]   nextAddr;
  logic [`DMA_ADDR_W-1:0]   nextCount;
  logic                     termCount;

  dmaBusDecode busDecode_i (
    .clk(clk), .arstN(arstN), .cs(cs), .rd(rd), .wr(wr),
    .regAddr(regAddr), .wrData(wrData),
    .cmd(cmd), .cmdChannel(cmdChannel), .hiByte(hiByte), .cmdData(cmdData)
  );

  dmaChannelRegs channelRegs_i (
    .clk(clk), .arstN(arstN),
    .cmd(cmd), .cmdChannel(cmdChannel), .hiByte(hiByte), .cmdData(cmdData),
    .dreq(dreq), .svcChannel(svcChannel),
    .update(update), .nextAddr(nextAddr), .nextCount(nextCount), .termCount(termCount),
    .chanAddr(chanAddr), .chanCount(chanCount), .chanDecrement(chanDecrement),
    .maskBits(maskBits), .rdData(rdData)
  );

  dmaTransferEngine transferEngine_i (
    .clk(clk), .arstN(arstN), .dreq(dreq), .maskBits(maskBits),
    .chanAddr(chanAddr), .chanCount(chanCount), .chanDecrement(chanDecrement),
    .svcChannel(svcChannel), .dack(dack), .memAddr(memAddr),
    .update(update), .nextAddr(nextAddr), .nextCount(nextCount), .termCount(termCount)
  );

endmodule

// File: dmaTransferEngine.sv
// Transfer engine with fixed priority arbiter, grant FSM and address/count stepping
`timescale 1ns/1ps
`include "dma_params.svh"

module dmaTransferEngine
  import dmaPkg::*;
(
  input  logic                     clk,
  input  logic                     arstN,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [`DMA_CHANNELS-1:0] maskBits,
  input  logic [`DMA_ADDR_W-1:0]   chanAddr,
  input  logic [`DMA_ADDR_W-1:0]   chanCount,
  input  logic                     chanDecrement,
  output logic [`DMA_CH_W-1:0]     svcChannel,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic [`DMA_ADDR_W-1:0]   memAddr,
  output logic                     update,
  output logic [`DMA_ADDR_W-1:0]   nextAddr,
  output logic [`DMA_ADDR_W-1:0]   nextCount,
  output logic                     termCount
);

  dmaEngStateE              state;
  logic [`DMA_CHANNELS-1:0] pending;
  logic [`DMA_CH_W-1:0]     pickChannel;

  // Lowest numbered unmasked request wins
  always_comb
  begin
    pending     = dreq & ~maskBits;
    pickChannel = '0;
    for (int i = `DMA_CHANNELS - 1; i >= 0; i--)
    begin
      if (pending[i])
        pickChannel = `DMA_CH_W'(i);
    end
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      state      <= engIdle;
      svcChannel <= '0;
    end
    else
    begin
      case (state)
        engIdle:
        begin
          if (|pending)
          begin
            svcChannel <= pickChannel;
            state      <= engGrant;
          end
        end
        engGrant:  state <= engUpdate;
        engUpdate: state <= engIdle;
        default:   state <= engIdle;
      endcase
    end
  end

  // One-cycle grant with the channel's current address
  assign dack    = (state == engGrant) ? (`DMA_CHANNELS'(1) << svcChannel) : '0;
  assign memAddr = (state == engGrant) ? chanAddr : '0;

  // Write-back values
  assign update    = (state == engUpdate);
  assign nextAddr  = chanDecrement ? chanAddr - 1'b1 : chanAddr + 1'b1;
  assign nextCount = chanCount - 1'b1;
  // Count already at zero means this was the last of N+1 transfers
  assign termCount = update && (chanCount == '0);

  dackOneHot: assert property (@(posedge clk) disable iff (!arstN)
    $onehot0(dack));

  // A grant answers a request that was unmasked when the engine arbitrated
  dackInGrant: assert property (@(posedge clk) disable iff (!arstN)
    (dack != '0) |-> ($past(state) == engIdle) && ((dack & $past(pending)) == dack));

endmodule

// File: dmaChannelRegs.sv
// Channel register file with base and current registers, mode, mask, status and read data
`timescale 1ns/1ps
`include "dma_params.svh"

module dmaChannelRegs
  import dmaPkg::*;
(
  input  logic                     clk,
  input  logic                     arstN,
  input  dmaCmdE                   cmd,
  input  logic [`DMA_CH_W-1:0]     cmdChannel,
  input  logic                     hiByte,
  input  logic [`DMA_DATA_W-1:0]   cmdData,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic [`DMA_CH_W-1:0]     svcChannel,
  input  logic                     update,
  input  logic [`DMA_ADDR_W-1:0]   nextAddr,
  input  logic [`DMA_ADDR_W-1:0]   nextCount,
  input  logic                     termCount,
  output logic [`DMA_ADDR_W-1:0]   chanAddr,
  output logic [`DMA_ADDR_W-1:0]   chanCount,
  output logic                     chanDecrement,
  output logic [`DMA_CHANNELS-1:0] maskBits,
  output logic [`DMA_DATA_W-1:0]   rdData
);

  logic [`DMA_ADDR_W-1:0]   baseAddr  [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curAddr   [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   baseCount [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curCount  [`DMA_CHANNELS];
  logic [`DMA_CHANNELS-1:0] autoInit;
  logic [`DMA_CHANNELS-1:0] decrement;
  logic [`DMA_CHANNELS-1:0] tcFlags;

  // Channel under service, seen by the engine
  assign chanAddr      = curAddr[svcChannel];
  assign chanCount     = curCount[svcChannel];
  assign chanDecrement = decrement[svcChannel];

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
      end
      autoInit  <= '0;
      decrement <= '0;
      maskBits  <= '0;
      tcFlags   <= '0;
    end
    else if (cmd == cmdMasterClr)
    begin
      for (int i = 0; i < `DMA_CHANNELS; i++)
      begin
        baseAddr[i]  <= '0;
        curAddr[i]   <= '0;
        baseCount[i] <= '0;
        curCount[i]  <= '0;
      end
      autoInit  <= '0;
      decrement <= '0;
      maskBits  <= '0;
      tcFlags   <= '0;
    end
    else
    begin
      // Engine write-back first so a CPU write further down takes over
      if (update)
      begin
        curAddr[svcChannel]  <= nextAddr;
        curCount[svcChannel] <= nextCount;
      end
      case (cmd)
        cmdWrAddr:
        begin
          if (hiByte)
          begin
            baseAddr[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W] <= cmdData;
            curAddr[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W]  <= cmdData;
          end
          else
          begin
            baseAddr[cmdChannel][0 +: `DMA_DATA_W] <= cmdData;
            curAddr[cmdChannel][0 +: `DMA_DATA_W]  <= cmdData;
          end
        end
        cmdWrCount:
        begin
          if (hiByte)
          begin
            baseCount[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W] <= cmdData;
            curCount[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W]  <= cmdData;
          end
          else
          begin
            baseCount[cmdChannel][0 +: `DMA_DATA_W] <= cmdData;
            curCount[cmdChannel][0 +: `DMA_DATA_W]  <= cmdData;
          end
        end
        cmdWrMode:
        begin
          autoInit[cmdChannel]  <= cmdData[4];
          decrement[cmdChannel] <= cmdData[5];
        end
        cmdRdStatus: tcFlags  <= '0;
        cmdClrMask:  maskBits <= '0;
        cmdWrMask:   maskBits <= cmdData[`DMA_CHANNELS-1:0];
        default:
        begin
        end
      endcase
      // Terminal count, placed last so a status read never loses the flag
      if (update && termCount)
      begin
        tcFlags[svcChannel] <= 1'b1;
        if (autoInit[svcChannel])
        begin
          curAddr[svcChannel]  <= baseAddr[svcChannel];
          curCount[svcChannel] <= baseCount[svcChannel];
        end
        else
          maskBits[svcChannel] <= 1'b1;
      end
    end
  end

  // Read data holds until the next read, master clear leaves it alone
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      rdData <= '0;
    else
    begin
      case (cmd)
        cmdRdAddr:
          rdData <= hiByte ? curAddr[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W]
                           : curAddr[cmdChannel][0 +: `DMA_DATA_W];
        cmdRdCount:
          rdData <= hiByte ? curCount[cmdChannel][`DMA_DATA_W +: `DMA_DATA_W]
                           : curCount[cmdChannel][0 +: `DMA_DATA_W];
        cmdRdStatus: rdData <= {dreq, tcFlags};
        default:
        begin
        end
      endcase
    end
  end

  // Engine only flags terminal count in its write-back cycle
  tcWithUpdate: assert property (@(posedge clk) disable iff (!arstN)
    termCount |-> update);

endmodule

// File: dmaBusDecode.sv
// CPU register port decoder with the byte pointer flip-flop
`timescale 1ns/1ps
`include "dma_params.svh"

module dmaBusDecode
  import dmaPkg::*;
(
  input  logic                       clk,
  input  logic                       arstN,
  input  logic                       cs,
  input  logic                       rd,
  input  logic                       wr,
  input  logic [`DMA_REG_ADDR_W-1:0] regAddr,
  input  logic [`DMA_DATA_W-1:0]     wrData,
  output dmaCmdE                     cmd,
  output logic [`DMA_CH_W-1:0]       cmdChannel,
  output logic                       hiByte,
  output logic [`DMA_DATA_W-1:0]     cmdData
);

  // Fixed register locations above the channel block
  localparam logic [`DMA_REG_ADDR_W-1:0] regStatus   = 8;
  localparam logic [`DMA_REG_ADDR_W-1:0] regMode     = 11;
  localparam logic [`DMA_REG_ADDR_W-1:0] regClrPtr   = 12;
  localparam logic [`DMA_REG_ADDR_W-1:0] regMasterCl = 13;
  localparam logic [`DMA_REG_ADDR_W-1:0] regClrMask  = 14;
  localparam logic [`DMA_REG_ADDR_W-1:0] regWrMask   = 15;

  dmaCmdE                 nextCmd;
  logic [`DMA_CH_W-1:0]   nextChannel;
  logic                   chanAccess;
  logic                   bytePtr;

  // Decode one access per cycle
  always_comb
  begin
    nextCmd     = cmdNone;
    nextChannel = regAddr[`DMA_CH_W:1];
    chanAccess  = 1'b0;
    if (cs && (rd != wr))
    begin
      if (!regAddr[`DMA_REG_ADDR_W-1])
      begin
        // Channel block, even is address and odd is count
        chanAccess = 1'b1;
        if (regAddr[0])
          nextCmd = wr ? cmdWrCount : cmdRdCount;
        else
          nextCmd = wr ? cmdWrAddr : cmdRdAddr;
      end
      else if (rd)
      begin
        if (regAddr == regStatus)
          nextCmd = cmdRdStatus;
      end
      else
      begin
        case (regAddr)
          regMode:
          begin
            nextCmd     = cmdWrMode;
            nextChannel = wrData[`DMA_CH_W-1:0];
          end
          regClrPtr:   nextCmd = cmdClrBytePtr;
          regMasterCl: nextCmd = cmdMasterClr;
          regClrMask:  nextCmd = cmdClrMask;
          regWrMask:   nextCmd = cmdWrMask;
          default:     nextCmd = cmdNone;
        endcase
      end
    end
  end

  // Byte pointer, low byte first
  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      bytePtr <= 1'b0;
    else if (nextCmd == cmdMasterClr || nextCmd == cmdClrBytePtr)
      bytePtr <= 1'b0;
    else if (chanAccess)
      bytePtr <= ~bytePtr;
  end

  always_ff @(posedge clk or negedge arstN)
  begin
    if (!arstN)
      cmd <= cmdNone;
    else
      cmd <= nextCmd;
  end

  // Command payload, only meaningful alongside cmd
  always_ff @(posedge clk)
  begin
    cmdChannel <= nextChannel;
    hiByte     <= bytePtr;
    cmdData    <= wrData;
  end

  // CPU must not strobe read and write together
  rdWrExclusive: assert property (@(posedge clk) disable iff (!arstN)
    cs |-> !(rd && wr));

endmodule

// File: dmaPkg.sv
// Package with the decoded command and transfer engine state enums
package dmaPkg;

  // Register operation handed from the bus decoder to the register file
  typedef enum logic [3:0] {
    cmdNone       = 4'd0,
    cmdWrAddr     = 4'd1,
    cmdWrCount    = 4'd2,
    cmdRdAddr     = 4'd3,
    cmdRdCount    = 4'd4,
    cmdRdStatus   = 4'd5,
    cmdWrMode     = 4'd6,
    cmdClrBytePtr = 4'd7,
    cmdMasterClr  = 4'd8,
    cmdClrMask    = 4'd9,
    cmdWrMask     = 4'd10
  } dmaCmdE;

  // Transfer engine states
  // engIdle   arbitrate among unmasked requests
  // engGrant  dack and memAddr out for one cycle
  // engUpdate write stepped address and count back
  typedef enum logic [1:0] {
    engIdle   = 2'd0,
    engGrant  = 2'd1,
    engUpdate = 2'd2
  } dmaEngStateE;

endpackage

// File: dma_params.svh
// Width and channel-count macros for the DMA controller
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Channel count is tied to the register map, channel sits in regAddr[2:1]
`define DMA_CHANNELS 4

// Address and word count width
`define DMA_ADDR_W 16

// CPU data port width
`define DMA_DATA_W 8

// Register port address width
`define DMA_REG_ADDR_W 4

// Channel index width
`define DMA_CH_W 2

`endif
